//--- design/wb_ic_pkg.sv
/* Widths, target ids and memory map of the 3x3 Wishbone interconnect.
   Regions not listed here decode to slave 0. */
`default_nettype none

package wb_ic_pkg;

  // ------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------
  localparam int WB_AW     = 32;
  localparam int WB_DW     = 32;
  localparam int WB_SW     = 4;
  localparam int GLBL_AW   = 8;
  localparam int N_MASTERS = 3;

  typedef logic [WB_AW-1:0]   wb_addr_t;
  typedef logic [WB_DW-1:0]   wb_data_t;
  typedef logic [WB_SW-1:0]   wb_sel_t;
  typedef logic [GLBL_AW-1:0] glbl_addr_t;
  typedef logic [1:0]         tid_t;

  // ------------------------------------------------------------------
  // Target ids and memory map
  // ------------------------------------------------------------------
  localparam tid_t TID_FLASH = 2'd0;
  localparam tid_t TID_SDRAM = 2'd1;
  localparam tid_t TID_GLBL  = 2'd2;

  // Top nibble of the address
  localparam logic [3:0] REGION_FLASH_LO = 4'h0;
  localparam logic [3:0] REGION_SPI_REG  = 4'h1;
  localparam logic [3:0] REGION_SDRAM    = 4'h2;

  // Upper half of the address for the global register block
  localparam logic [15:0] GLBL_PAGE = 16'h3000;

  // Arbiter and staging state machines
  typedef enum logic [1:0] {GNT_M0, GNT_M1, GNT_M2} gnt_t;
  typedef enum logic [1:0] {STG_IDLE, STG_BUSY, STG_RESP} stage_state_t;

endpackage

`default_nettype wire

//--- design/wb_bus_if.sv
/* Internal Wishbone path carrying one request plus its target id.
   No err signal, slaves are assumed never to fail. */
`default_nettype none

interface wb_bus_if
  import wb_ic_pkg::*;
();

  // Request side
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_sel_t  sel;
  logic     we;
  logic     cyc;
  logic     stb;
  // Decoded slave for this request
  tid_t     tid;

  // Response side
  wb_data_t dat_r;
  logic     ack;

  // Side that issues the request
  modport mst (
    output adr, dat_w, sel, we, cyc, stb, tid,
    input  dat_r, ack
  );

  // Side that answers it
  modport slv (
    input  adr, dat_w, sel, we, cyc, stb, tid,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- design/wb_arbiter.sv
/* Round-robin grant over three masters, registered.
   A grant is held for as long as the granted master keeps requesting. */
`default_nettype none

module wb_arbiter
  import wb_ic_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [N_MASTERS-1:0] req_i,
  output gnt_t                 gnt_o
);

  gnt_t gnt_d;

  // ------------------------------------------------------------------
  // Next grant
  // ------------------------------------------------------------------
  // Search starts after the current owner and wraps around
  always_comb begin
    gnt_d = gnt_o;
    case (gnt_o)
      GNT_M0: begin
        if (!req_i[0]) begin
          if (req_i[1])      gnt_d = GNT_M1;
          else if (req_i[2]) gnt_d = GNT_M2;
        end
      end
      GNT_M1: begin
        if (!req_i[1]) begin
          if (req_i[2])      gnt_d = GNT_M2;
          else if (req_i[0]) gnt_d = GNT_M0;
        end
      end
      GNT_M2: begin
        if (!req_i[2]) begin
          if (req_i[0])      gnt_d = GNT_M0;
          else if (req_i[1]) gnt_d = GNT_M1;
        end
      end
      default: gnt_d = GNT_M0;
    endcase
  end

  // Grant register, m0 owns the bus after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_o <= GNT_M0;
    end else begin
      gnt_o <= gnt_d;
    end
  end

  // Encoding 3 must never be reached
  a_gnt_legal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_o inside {GNT_M0, GNT_M1, GNT_M2});

  // No master loses the bus in the middle of its transfer
  a_gnt_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i[gnt_o] |=> $stable(gnt_o));

endmodule

`default_nettype wire

//--- design/wb_master_mux.sv
/* Puts the granted master on the internal bus and decodes its target.
   Masters without the grant see zero data and no ack. */
`default_nettype none

module wb_master_mux
  import wb_ic_pkg::*;
(
  input  gnt_t     gnt_i,
  input  wb_addr_t m0_adr_i,
  input  wb_addr_t m1_adr_i,
  input  wb_addr_t m2_adr_i,
  input  wb_data_t m0_dat_i,
  input  wb_data_t m1_dat_i,
  input  wb_data_t m2_dat_i,
  input  wb_sel_t  m0_sel_i,
  input  wb_sel_t  m1_sel_i,
  input  wb_sel_t  m2_sel_i,
  input  logic     m0_we_i,
  input  logic     m1_we_i,
  input  logic     m2_we_i,
  input  logic     m0_cyc_i,
  input  logic     m1_cyc_i,
  input  logic     m2_cyc_i,
  input  logic     m0_stb_i,
  input  logic     m1_stb_i,
  input  logic     m2_stb_i,
  output wb_data_t m0_dat_o,
  output wb_data_t m1_dat_o,
  output wb_data_t m2_dat_o,
  output logic     m0_ack_o,
  output logic     m1_ack_o,
  output logic     m2_ack_o,
  wb_bus_if.mst    bus
);

  wb_addr_t mux_adr;

  // ------------------------------------------------------------------
  // Memory map decode
  // ------------------------------------------------------------------
  // Flash and SPI registers share slave 0, holes fall there too
  function automatic tid_t decode_tid(input wb_addr_t adr);
    tid_t tid;
    if (adr[31:28] == REGION_FLASH_LO || adr[31:28] == REGION_SPI_REG) begin
      tid = TID_FLASH;
    end else if (adr[31:28] == REGION_SDRAM) begin
      tid = TID_SDRAM;
    end else if (adr[31:16] == GLBL_PAGE) begin
      tid = TID_GLBL;
    end else begin
      tid = TID_FLASH;
    end
    return tid;
  endfunction

  // ------------------------------------------------------------------
  // Request mux
  // ------------------------------------------------------------------
  always_comb begin
    case (gnt_i)
      GNT_M1: begin
        mux_adr   = m1_adr_i;
        bus.dat_w = m1_dat_i;
        bus.sel   = m1_sel_i;
        bus.we    = m1_we_i;
        bus.cyc   = m1_cyc_i;
        bus.stb   = m1_stb_i;
      end
      GNT_M2: begin
        mux_adr   = m2_adr_i;
        bus.dat_w = m2_dat_i;
        bus.sel   = m2_sel_i;
        bus.we    = m2_we_i;
        bus.cyc   = m2_cyc_i;
        bus.stb   = m2_stb_i;
      end
      default: begin
        mux_adr   = m0_adr_i;
        bus.dat_w = m0_dat_i;
        bus.sel   = m0_sel_i;
        bus.we    = m0_we_i;
        bus.cyc   = m0_cyc_i;
        bus.stb   = m0_stb_i;
      end
    endcase
  end

  // Word access only, byte lanes come from sel
  assign bus.adr = {mux_adr[WB_AW-1:2], 2'b00};
  assign bus.tid = decode_tid(mux_adr);

  // Response goes back to the owner only
  assign m0_dat_o = (gnt_i == GNT_M0) ? bus.dat_r : '0;
  assign m1_dat_o = (gnt_i == GNT_M1) ? bus.dat_r : '0;
  assign m2_dat_o = (gnt_i == GNT_M2) ? bus.dat_r : '0;
  assign m0_ack_o = (gnt_i == GNT_M0) & bus.ack;
  assign m1_ack_o = (gnt_i == GNT_M1) & bus.ack;
  assign m2_ack_o = (gnt_i == GNT_M2) & bus.ack;

endmodule

`default_nettype wire

//--- design/wb_stage.sv
/* One register stage between master and slave side, one transfer in flight.
   Master ack comes one cycle after slave ack and lasts one cycle. */
`default_nettype none

module wb_stage
  import wb_ic_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  wb_bus_if.slv up,
  wb_bus_if.mst dn
);

  stage_state_t state_q;
  logic         take_req;

  // New request accepted only when idle and not being acked
  assign take_req = (state_q == STG_IDLE) && up.cyc && up.stb && !up.ack;

  // ------------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= STG_IDLE;
      dn.cyc   <= 1'b0;
      dn.stb   <= 1'b0;
      up.ack   <= 1'b0;
      up.dat_r <= '0;
    end else begin
      case (state_q)
        STG_IDLE: begin
          if (take_req) begin
            dn.cyc  <= 1'b1;
            dn.stb  <= 1'b1;
            state_q <= STG_BUSY;
          end
        end
        STG_BUSY: begin
          // Slave may stretch this state as long as it likes
          if (dn.ack) begin
            dn.cyc   <= 1'b0;
            dn.stb   <= 1'b0;
            up.ack   <= 1'b1;
            up.dat_r <= dn.dat_r;
            state_q  <= STG_RESP;
          end
        end
        STG_RESP: begin
          // Single ack pulse toward the master
          up.ack  <= 1'b0;
          state_q <= STG_IDLE;
        end
        default: begin
          state_q <= STG_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Request payload
  // ------------------------------------------------------------------
  // Loaded once per transfer and held until the slave answers
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      dn.adr   <= up.adr;
      dn.dat_w <= up.dat_w;
      dn.sel   <= up.sel;
      dn.we    <= up.we;
      dn.tid   <= up.tid;
    end
  end

  // Slave side sees a stable request until it acks
  a_dn_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dn.stb && !dn.ack) |=>
      $stable({dn.adr, dn.dat_w, dn.sel, dn.we, dn.tid}));

endmodule

`default_nettype wire

//--- design/wb_slave_demux.sv
/* Routes the staged request to one slave by target id, others get zero.
   Slave 1 sees its top nibble cleared, slave 2 only 8 address bits. */
`default_nettype none

module wb_slave_demux
  import wb_ic_pkg::*;
(
  wb_bus_if.slv      bus,
  output wb_addr_t   s0_adr_o,
  output wb_addr_t   s1_adr_o,
  output glbl_addr_t s2_adr_o,
  output wb_data_t   s0_dat_o,
  output wb_data_t   s1_dat_o,
  output wb_data_t   s2_dat_o,
  output wb_sel_t    s0_sel_o,
  output wb_sel_t    s1_sel_o,
  output wb_sel_t    s2_sel_o,
  output logic       s0_we_o,
  output logic       s1_we_o,
  output logic       s2_we_o,
  output logic       s0_cyc_o,
  output logic       s1_cyc_o,
  output logic       s2_cyc_o,
  output logic       s0_stb_o,
  output logic       s1_stb_o,
  output logic       s2_stb_o,
  input  wb_data_t   s0_dat_i,
  input  wb_data_t   s1_dat_i,
  input  wb_data_t   s2_dat_i,
  input  logic       s0_ack_i,
  input  logic       s1_ack_i,
  input  logic       s2_ack_i
);

  logic hit0;
  logic hit1;
  logic hit2;

  // Id 3 is never decoded, treat it as flash
  assign hit0 = (bus.tid != TID_SDRAM) && (bus.tid != TID_GLBL);
  assign hit1 = (bus.tid == TID_SDRAM);
  assign hit2 = (bus.tid == TID_GLBL);

  // ------------------------------------------------------------------
  // Request fan-out
  // ------------------------------------------------------------------
  assign s0_adr_o = hit0 ? bus.adr : '0;
  assign s0_dat_o = hit0 ? bus.dat_w : '0;
  assign s0_sel_o = hit0 ? bus.sel : '0;
  assign s0_we_o  = hit0 & bus.we;
  assign s0_cyc_o = hit0 & bus.cyc;
  assign s0_stb_o = hit0 & bus.stb;

  // SDRAM offset within its region
  assign s1_adr_o = hit1 ? {4'h0, bus.adr[WB_AW-5:0]} : '0;
  assign s1_dat_o = hit1 ? bus.dat_w : '0;
  assign s1_sel_o = hit1 ? bus.sel : '0;
  assign s1_we_o  = hit1 & bus.we;
  assign s1_cyc_o = hit1 & bus.cyc;
  assign s1_stb_o = hit1 & bus.stb;

  // Global register file decodes a byte address only
  assign s2_adr_o = hit2 ? bus.adr[GLBL_AW-1:0] : '0;
  assign s2_dat_o = hit2 ? bus.dat_w : '0;
  assign s2_sel_o = hit2 ? bus.sel : '0;
  assign s2_we_o  = hit2 & bus.we;
  assign s2_cyc_o = hit2 & bus.cyc;
  assign s2_stb_o = hit2 & bus.stb;

  // ------------------------------------------------------------------
  // Response select
  // ------------------------------------------------------------------
  always_comb begin
    case (bus.tid)
      TID_SDRAM: begin
        bus.dat_r = s1_dat_i;
        bus.ack   = s1_ack_i;
      end
      TID_GLBL: begin
        bus.dat_r = s2_dat_i;
        bus.ack   = s2_ack_i;
      end
      default: begin
        bus.dat_r = s0_dat_i;
        bus.ack   = s0_ack_i;
      end
    endcase
  end

  // Never more than one slave strobed
  always_comb begin
    a_one_slave : assert ($onehot0({s0_stb_o, s1_stb_o, s2_stb_o}));
  end

endmodule

`default_nettype wire

//--- design/wb_interconnect.sv
/* Shared-bus Wishbone classic interconnect, 3 masters to 3 slaves.
   Masters must drop stb for a cycle after each ack, no err signalling. */
`default_nettype none

module wb_interconnect
  import wb_ic_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Master 0, external host
  input  wb_addr_t   m0_adr_i,
  input  wb_data_t   m0_dat_i,
  input  wb_sel_t    m0_sel_i,
  input  logic       m0_we_i,
  input  logic       m0_cyc_i,
  input  logic       m0_stb_i,
  output wb_data_t   m0_dat_o,
  output logic       m0_ack_o,

  // Master 1, instruction fetch
  input  wb_addr_t   m1_adr_i,
  input  wb_data_t   m1_dat_i,
  input  wb_sel_t    m1_sel_i,
  input  logic       m1_we_i,
  input  logic       m1_cyc_i,
  input  logic       m1_stb_i,
  output wb_data_t   m1_dat_o,
  output logic       m1_ack_o,

  // Master 2, data access
  input  wb_addr_t   m2_adr_i,
  input  wb_data_t   m2_dat_i,
  input  wb_sel_t    m2_sel_i,
  input  logic       m2_we_i,
  input  logic       m2_cyc_i,
  input  logic       m2_stb_i,
  output wb_data_t   m2_dat_o,
  output logic       m2_ack_o,

  // Slave 0, SPI flash and SPI registers
  output wb_addr_t   s0_adr_o,
  output wb_data_t   s0_dat_o,
  output wb_sel_t    s0_sel_o,
  output logic       s0_we_o,
  output logic       s0_cyc_o,
  output logic       s0_stb_o,
  input  wb_data_t   s0_dat_i,
  input  logic       s0_ack_i,

  // Slave 1, SDRAM
  output wb_addr_t   s1_adr_o,
  output wb_data_t   s1_dat_o,
  output wb_sel_t    s1_sel_o,
  output logic       s1_we_o,
  output logic       s1_cyc_o,
  output logic       s1_stb_o,
  input  wb_data_t   s1_dat_i,
  input  logic       s1_ack_i,

  // Slave 2, global registers
  output glbl_addr_t s2_adr_o,
  output wb_data_t   s2_dat_o,
  output wb_sel_t    s2_sel_o,
  output logic       s2_we_o,
  output logic       s2_cyc_o,
  output logic       s2_stb_o,
  input  wb_data_t   s2_dat_i,
  input  logic       s2_ack_i
);

  wb_bus_if m_bus ();
  wb_bus_if s_bus ();

  gnt_t                 gnt;
  logic [N_MASTERS-1:0] m_req;

  // A master stops requesting in its ack cycle
  assign m_req = {m2_stb_i & ~m2_ack_o, m1_stb_i & ~m1_ack_o, m0_stb_i & ~m0_ack_o};

  // ------------------------------------------------------------------
  // Master side
  // ------------------------------------------------------------------
  wb_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (m_req),
    .gnt_o   (gnt)
  );

  wb_master_mux u_master_mux (
    .gnt_i    (gnt),
    .m0_adr_i (m0_adr_i),
    .m1_adr_i (m1_adr_i),
    .m2_adr_i (m2_adr_i),
    .m0_dat_i (m0_dat_i),
    .m1_dat_i (m1_dat_i),
    .m2_dat_i (m2_dat_i),
    .m0_sel_i (m0_sel_i),
    .m1_sel_i (m1_sel_i),
    .m2_sel_i (m2_sel_i),
    .m0_we_i  (m0_we_i),
    .m1_we_i  (m1_we_i),
    .m2_we_i  (m2_we_i),
    .m0_cyc_i (m0_cyc_i),
    .m1_cyc_i (m1_cyc_i),
    .m2_cyc_i (m2_cyc_i),
    .m0_stb_i (m0_stb_i),
    .m1_stb_i (m1_stb_i),
    .m2_stb_i (m2_stb_i),
    .m0_dat_o (m0_dat_o),
    .m1_dat_o (m1_dat_o),
    .m2_dat_o (m2_dat_o),
    .m0_ack_o (m0_ack_o),
    .m1_ack_o (m1_ack_o),
    .m2_ack_o (m2_ack_o),
    .bus      (m_bus.mst)
  );

  // Breaks the path between master mux and slave decode
  wb_stage u_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .up      (m_bus.slv),
    .dn      (s_bus.mst)
  );

  // ------------------------------------------------------------------
  // Slave side
  // ------------------------------------------------------------------
  wb_slave_demux u_slave_demux (
    .bus      (s_bus.slv),
    .s0_adr_o (s0_adr_o),
    .s1_adr_o (s1_adr_o),
    .s2_adr_o (s2_adr_o),
    .s0_dat_o (s0_dat_o),
    .s1_dat_o (s1_dat_o),
    .s2_dat_o (s2_dat_o),
    .s0_sel_o (s0_sel_o),
    .s1_sel_o (s1_sel_o),
    .s2_sel_o (s2_sel_o),
    .s0_we_o  (s0_we_o),
    .s1_we_o  (s1_we_o),
    .s2_we_o  (s2_we_o),
    .s0_cyc_o (s0_cyc_o),
    .s1_cyc_o (s1_cyc_o),
    .s2_cyc_o (s2_cyc_o),
    .s0_stb_o (s0_stb_o),
    .s1_stb_o (s1_stb_o),
    .s2_stb_o (s2_stb_o),
    .s0_dat_i (s0_dat_i),
    .s1_dat_i (s1_dat_i),
    .s2_dat_i (s2_dat_i),
    .s0_ack_i (s0_ack_i),
    .s1_ack_i (s1_ack_i),
    .s2_ack_i (s2_ack_i)
  );

endmodule

`default_nettype wire

//--- dv/wb_ic_tests.svh
/* Driver, compare and directed test tasks, included in the testbench top.
   Tasks start and return 2 ns after a rising clock edge. */
`ifndef WB_IC_TESTS_SVH
`define WB_IC_TESTS_SVH

// ------------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------------
task automatic stop_on_error(input string what);
  $display("%s", what);
  $display("ERRORS FOUND");
  $fatal(1);
endtask

task automatic chk_data(input string name, input wb_data_t got, input wb_data_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic chk_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic chk_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic chk_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic chk_master(input string name, input int got, input int exp);
  if (got != exp) begin
    stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// Address as slave idx received it with slave 2 zero-extended
function automatic wb_addr_t seen_adr(input int idx);
  case (idx)
    0:       return s0_adr;
    1:       return s1_adr;
    default: return {24'h0, s2_adr};
  endcase
endfunction

// ------------------------------------------------------------------
// Master driver
// ------------------------------------------------------------------
task automatic start_req(input int mi, input wb_addr_t adr, input logic we,
                         input wb_data_t dat, input wb_sel_t sel);
  m_adr[mi]  = adr;
  m_wdat[mi] = dat;
  m_sel[mi]  = sel;
  m_we[mi]   = we;
  m_cyc[mi]  = 1'b1;
  m_stb[mi]  = 1'b1;
endtask

// Waits for ack, drops the request and leaves one idle cycle
task automatic wait_ack(input int mi, input bit excl, output wb_data_t rdat);
  int n;
  n = 0;
  rdat = '0;
  forever begin
    @(posedge clk);
    #1;
    n++;
    if (excl) begin
      for (int j = 0; j < 3; j++) begin
        if (j != mi) chk_bit($sformatf("m%0d_ack_o", j), m_ack[j], 1'b0);
      end
    end
    if (m_ack[mi]) break;
    if (n > 50) stop_on_error($sformatf("Timeout while master %0d waited for its ack", mi));
  end
  rdat = m_rdat[mi];
  #1;
  m_cyc[mi] = 1'b0;
  m_stb[mi] = 1'b0;
  m_we[mi]  = 1'b0;
  @(posedge clk);
  #2;
endtask

task automatic bus_xfer(input int mi, input wb_addr_t adr, input logic we,
                        input wb_data_t dat, input wb_sel_t sel, input bit excl,
                        output wb_data_t rdat);
  start_req(mi, adr, we, dat, sel);
  wait_ack(mi, excl, rdat);
endtask

// ------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------
task automatic check_idle(input int cycles);
  repeat (cycles) begin
    @(posedge clk);
    #1;
    for (int i = 0; i < 3; i++) begin
      chk_bit($sformatf("s%0d_cyc_o", i), s_cyc[i], 1'b0);
      chk_bit($sformatf("s%0d_stb_o", i), s_stb[i], 1'b0);
      chk_bit($sformatf("m%0d_ack_o", i), m_ack[i], 1'b0);
    end
  end
  #1;
endtask

task automatic test_round_robin();
  wb_data_t r0;
  wb_data_t r1;
  wb_data_t r2;
  int base;
  base = ack_order.size();
  fork
    bus_xfer(0, 32'h0000_0010, 1'b0, '0, 4'hF, 1'b0, r0);
    bus_xfer(1, 32'h2000_0020, 1'b0, '0, 4'hF, 1'b0, r1);
    bus_xfer(2, 32'h3000_0030, 1'b0, '0, 4'hF, 1'b0, r2);
  join
  if (ack_order.size() != base + 3) stop_on_error("Wrong number of acks in round robin");
  chk_master("first ack", ack_order[base], 0);
  chk_master("second ack", ack_order[base + 1], 1);
  chk_master("third ack", ack_order[base + 2], 2);

  // m2 still holds the grant while m0 asks first and is served first
  base = ack_order.size();
  fork
    bus_xfer(0, 32'h0000_0040, 1'b0, '0, 4'hF, 1'b0, r0);
    begin
      @(posedge clk);
      #2;
      bus_xfer(2, 32'h0000_0050, 1'b0, '0, 4'hF, 1'b0, r2);
    end
  join
  if (ack_order.size() != base + 2) stop_on_error("Wrong number of acks in second round");
  chk_master("first ack", ack_order[base], 0);
  chk_master("second ack", ack_order[base + 1], 2);
endtask

task automatic test_decode();
  wb_addr_t in_adr [5];
  wb_addr_t trim [5];
  int       tgt [5];
  wb_data_t rd;
  int       n;
  in_adr = '{32'h0000_0104, 32'h1000_0008, 32'h2000_0010, 32'h3000_0024, 32'h5000_0003};
  trim   = '{32'h0000_0104, 32'h1000_0008, 32'h0000_0010, 32'h0000_0024, 32'h5000_0000};
  tgt    = '{0, 0, 1, 2, 0};
  for (int k = 0; k < 5; k++) begin
    start_req(0, in_adr[k], 1'b1, ~in_adr[k], wb_sel_t'(k + 1));
    n = 0;
    forever begin
      @(posedge clk);
      #1;
      n++;
      if (s_stb[tgt[k]]) break;
      if (n > 20) stop_on_error($sformatf("Timeout waiting for stb at slave %0d", tgt[k]));
    end
    for (int i = 0; i < 3; i++) begin
      chk_bit($sformatf("s%0d_stb_o", i), s_stb[i], i == tgt[k]);
      chk_bit($sformatf("s%0d_cyc_o", i), s_cyc[i], i == tgt[k]);
    end
    chk_addr($sformatf("s%0d_adr_o", tgt[k]), seen_adr(tgt[k]), trim[k]);
    chk_data($sformatf("s%0d_dat_o", tgt[k]), s_wdat[tgt[k]], ~in_adr[k]);
    chk_sel($sformatf("s%0d_sel_o", tgt[k]), s_sel[tgt[k]], wb_sel_t'(k + 1));
    chk_bit($sformatf("s%0d_we_o", tgt[k]), s_we[tgt[k]], 1'b1);
    wait_ack(0, 1'b1, rd);
  end
endtask

task automatic test_read_path();
  wb_addr_t rd_adr [3];
  wb_addr_t trim [3];
  wb_data_t rd;
  rd_adr = '{32'h0000_0040, 32'h2123_4568, 32'h3000_00A8};
  trim   = '{32'h0000_0040, 32'h0123_4568, 32'h0000_00A8};
  for (int mi = 0; mi < 3; mi++) begin
    for (int k = 0; k < 3; k++) begin
      bus_xfer(mi, rd_adr[k], 1'b0, '0, 4'hF, 1'b1, rd);
      chk_data($sformatf("m%0d_dat_o", mi), rd, (wb_data_t'(k) << 24) ^ trim[k]);
    end
  end
endtask

// Slave 1 stalls 0 to 3 cycles and is sampled 3 ns after each edge
task automatic test_back_pressure();
  wb_addr_t adr_q;
  wb_data_t dat_q;
  wb_sel_t  sel_q;
  bit       held;
  int       n;
  for (int k = 0; k < 4; k++) begin
    start_req(2, 32'h2000_0100 + wb_addr_t'(k * 4), 1'b1, 32'hC0DE_0000 + k, 4'hA);
    held = 1'b0;
    n = 0;
    #1;
    forever begin
      if (s_stb[1] && !held) begin
        adr_q = s1_adr;
        dat_q = s_wdat[1];
        sel_q = s_sel[1];
        held  = 1'b1;
      end else if (s_stb[1]) begin
        chk_addr("s1_adr_o", s1_adr, adr_q);
        chk_data("s1_dat_o", s_wdat[1], dat_q);
        chk_sel("s1_sel_o", s_sel[1], sel_q);
        chk_bit("s1_we_o", s_we[1], 1'b1);
      end
      if (s_ack[1]) break;
      chk_bit("m2_ack_o", m_ack[2], 1'b0);
      @(posedge clk);
      #3;
      n++;
      if (n > 20) stop_on_error("Timeout waiting for slave 1 to ack under back-pressure");
    end
    chk_addr("s1_adr_o", adr_q, 32'h0000_0100 + wb_addr_t'(k * 4));
    // Master ack is due in the next cycle
    @(posedge clk);
    #2;
    m_cyc[2] = 1'b0;
    m_stb[2] = 1'b0;
    m_we[2]  = 1'b0;
    #1;
    chk_bit("m2_ack_o", m_ack[2], 1'b1);
    @(posedge clk);
    #3;
    chk_bit("m2_ack_o", m_ack[2], 1'b0);
    @(posedge clk);
    #2;
  end
endtask

`endif

//--- dv/tb_wb_interconnect.sv
/* Testbench for the 3x3 Wishbone interconnect with a model of the three slaves.
   Slave ack latency of 0 to 3 cycles comes from a fixed seed. */
`default_nettype none

module tb_wb_interconnect
  import wb_ic_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic rst_n;

  // Master side
  wb_addr_t   m_adr [3];
  wb_data_t   m_wdat [3];
  wb_sel_t    m_sel [3];
  logic [2:0] m_we;
  logic [2:0] m_cyc;
  logic [2:0] m_stb;
  wb_data_t   m_rdat [3];
  logic [2:0] m_ack;

  // Slave side
  wb_addr_t   s0_adr;
  wb_addr_t   s1_adr;
  glbl_addr_t s2_adr;
  wb_data_t   s_wdat [3];
  wb_sel_t    s_sel [3];
  logic [2:0] s_we;
  logic [2:0] s_cyc;
  logic [2:0] s_stb;
  wb_data_t   s_rdat [3];
  logic [2:0] s_ack;

  integer     seed;
  // Master index of every ack, in arrival order
  int         ack_order [$];

  always #10 clk = ~clk;

  wb_interconnect u_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .m0_adr_i (m_adr[0]),
    .m0_dat_i (m_wdat[0]),
    .m0_sel_i (m_sel[0]),
    .m0_we_i  (m_we[0]),
    .m0_cyc_i (m_cyc[0]),
    .m0_stb_i (m_stb[0]),
    .m0_dat_o (m_rdat[0]),
    .m0_ack_o (m_ack[0]),
    .m1_adr_i (m_adr[1]),
    .m1_dat_i (m_wdat[1]),
    .m1_sel_i (m_sel[1]),
    .m1_we_i  (m_we[1]),
    .m1_cyc_i (m_cyc[1]),
    .m1_stb_i (m_stb[1]),
    .m1_dat_o (m_rdat[1]),
    .m1_ack_o (m_ack[1]),
    .m2_adr_i (m_adr[2]),
    .m2_dat_i (m_wdat[2]),
    .m2_sel_i (m_sel[2]),
    .m2_we_i  (m_we[2]),
    .m2_cyc_i (m_cyc[2]),
    .m2_stb_i (m_stb[2]),
    .m2_dat_o (m_rdat[2]),
    .m2_ack_o (m_ack[2]),
    .s0_adr_o (s0_adr),
    .s0_dat_o (s_wdat[0]),
    .s0_sel_o (s_sel[0]),
    .s0_we_o  (s_we[0]),
    .s0_cyc_o (s_cyc[0]),
    .s0_stb_o (s_stb[0]),
    .s0_dat_i (s_rdat[0]),
    .s0_ack_i (s_ack[0]),
    .s1_adr_o (s1_adr),
    .s1_dat_o (s_wdat[1]),
    .s1_sel_o (s_sel[1]),
    .s1_we_o  (s_we[1]),
    .s1_cyc_o (s_cyc[1]),
    .s1_stb_o (s_stb[1]),
    .s1_dat_i (s_rdat[1]),
    .s1_ack_i (s_ack[1]),
    .s2_adr_o (s2_adr),
    .s2_dat_o (s_wdat[2]),
    .s2_sel_o (s_sel[2]),
    .s2_we_o  (s_we[2]),
    .s2_cyc_o (s_cyc[2]),
    .s2_stb_o (s_stb[2]),
    .s2_dat_i (s_rdat[2]),
    .s2_ack_i (s_ack[2])
  );

  `include "wb_ic_tests.svh"

  // ------------------------------------------------------------------
  // Slave models
  // ------------------------------------------------------------------
  // Only one transfer is in flight, so one process answers all three
  initial begin : slave_model
    int idx;
    int delay;
    s_ack = '0;
    for (int i = 0; i < 3; i++) begin
      s_rdat[i] = '0;
    end
    forever begin
      @(posedge clk);
      #1;
      idx = -1;
      for (int i = 0; i < 3; i++) begin
        if (s_stb[i] && s_cyc[i] && !s_ack[i]) idx = i;
      end
      if (idx >= 0) begin
        delay = int'($unsigned($random(seed)) % 4);
        #1;
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        // Slave index in the top byte XORed with the address it received
        s_rdat[idx] = (wb_data_t'(idx) << 24) ^ seen_adr(idx);
        s_ack[idx]  = 1'b1;
        @(posedge clk);
        #2;
        s_ack[idx]  = 1'b0;
      end
    end
  end

  // Records which master got each ack
  always begin
    @(posedge clk);
    #1;
    for (int i = 0; i < 3; i++) begin
      if (m_ack[i]) ack_order.push_back(i);
    end
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    seed  = 62;
    clk   = 1'b0;
    rst_n = 1'b0;
    for (int i = 0; i < 3; i++) begin
      m_adr[i]  = '0;
      m_wdat[i] = '0;
      m_sel[i]  = '0;
    end
    m_we  = '0;
    m_cyc = '0;
    m_stb = '0;

    check_idle(3);
    rst_n = 1'b1;
    test_round_robin();
    check_idle(2);
    test_decode();
    test_read_path();
    test_back_pressure();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/wb_ic_pkg.sv
design/wb_bus_if.sv
design/wb_arbiter.sv
design/wb_master_mux.sv
design/wb_stage.sv
design/wb_slave_demux.sv
design/wb_interconnect.sv
+incdir+dv
dv/tb_wb_interconnect.sv

//--- Makefile
TOP := tb_wb_interconnect

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
